//--- rtl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Address the program counter loads when reset_n is low
`define CPU_RESET_VECTOR 32'h0000_0000

// Instruction RAM word address width
// The upper bits of the program counter are ignored by the fetch port
`define CPU_IMEM_ADDR_BITS 8

// Data RAM word address width
`define CPU_DMEM_ADDR_BITS 8

`endif

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;      // Data, address or instruction word
    typedef logic [3:0]  regIndex_t;  // 0 is zero, 15 is the PC

    // Comparisons return all ones for true
    typedef enum logic [3:0] {
        opOr     = 4'h0,
        opAnd    = 4'h1,
        opAdd    = 4'h2,
        opMul    = 4'h3,
        opRsvd4  = 4'h4,
        opShl    = 4'h5,
        opLt     = 4'h6,
        opEq     = 4'h7,
        opGt     = 4'h8,
        opAndNot = 4'h9,
        opXor    = 4'hA,
        opSub    = 4'hB,
        opXnor   = 4'hC,
        opShr    = 4'hD,
        opNe     = 4'hE,
        opRsvdF  = 4'hF
    } aluOp_t;

    typedef enum logic [1:0] {
        phaseIdle   = 2'd0,   // Startup and halted
        phaseExec   = 2'd1,
        phaseCommit = 2'd2
    } corePhase_t;

    typedef struct packed {
        regIndex_t idxZ;
        regIndex_t idxX;
        regIndex_t idxY;
        aluOp_t    op;
        word_t     imm;       // Sign extended from 12 bits
        logic      typeSel;   // Set swaps Y and A operands
        logic      storing;
        logic      derefRhs;
        logic      illegal;
        logic      branch;
    } insnFields_t;

    typedef struct packed {
        logic  writeEn;
        word_t addr;
        word_t data;
    } memReq_t;

endpackage

//--- rtl/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder (
    input  cpu_pkg::word_t       insn,
    output cpu_pkg::insnFields_t fields
);

    logic [11:0] immRaw;

    assign immRaw = insn[11:0];

    always_comb begin
        fields.typeSel  = insn[30];
        fields.storing  = insn[29];
        fields.derefRhs = insn[28];
        fields.idxZ     = insn[27:24];
        fields.idxX     = insn[23:20];
        fields.idxY     = insn[19:16];
        fields.op       = cpu_pkg::aluOp_t'(insn[15:12]);
        fields.imm      = {{20{immRaw[11]}}, immRaw};

        fields.illegal  = &insn;                       // All ones word halts
        fields.branch   = (&insn[27:24]) && !insn[29]; // Register write to PC
    end

endmodule

//--- rtl/aluExec.sv
`timescale 1ns/1ps

module aluExec (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            execEn,
    input  cpu_pkg::aluOp_t op,
    input  cpu_pkg::word_t  opX,
    input  cpu_pkg::word_t  opY,
    input  cpu_pkg::word_t  opA,
    output cpu_pkg::word_t  result
);

    cpu_pkg::word_t funcXY;
    logic           signedLt;
    logic           signedGt;

    assign signedLt = $signed(opX) < $signed(opY);
    assign signedGt = $signed(opX) > $signed(opY);

    always_comb begin
        case (op)
            cpu_pkg::opOr:     funcXY = opX | opY;
            cpu_pkg::opAnd:    funcXY = opX & opY;
            cpu_pkg::opAdd:    funcXY = opX + opY;
            cpu_pkg::opMul:    funcXY = opX * opY;      // Low 32 bits of product
            cpu_pkg::opShl:    funcXY = opX << opY;     // Zero for shifts of 32 or more
            cpu_pkg::opLt:     funcXY = {32{signedLt}};
            cpu_pkg::opEq:     funcXY = {32{opX == opY}};
            cpu_pkg::opGt:     funcXY = {32{signedGt}};
            cpu_pkg::opAndNot: funcXY = opX & ~opY;
            cpu_pkg::opXor:    funcXY = opX ^ opY;
            cpu_pkg::opSub:    funcXY = opX - opY;
            cpu_pkg::opXnor:   funcXY = opX ^~ opY;
            cpu_pkg::opShr:    funcXY = opX >> opY;     // Logical
            cpu_pkg::opNe:     funcXY = {32{opX != opY}};
            default:           funcXY = '0;             // Reserved ops give A
        endcase
    end

    // Result holds between exec cycles for the commit phase
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result <= '0;
        end else if (execEn) begin
            result <= funcXY + opA;
        end
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::word_t     pcPlusOne,
    input  cpu_pkg::regIndex_t idxX,
    input  cpu_pkg::regIndex_t idxY,
    input  cpu_pkg::regIndex_t idxZ,
    output cpu_pkg::word_t     valX,
    output cpu_pkg::word_t     valY,
    output cpu_pkg::word_t     valZ,
    input  logic               writeEn,
    input  cpu_pkg::word_t     writeData
);

    cpu_pkg::word_t regs [1:14];

    function automatic cpu_pkg::word_t readReg(cpu_pkg::regIndex_t idx);
        if (idx == 4'd0) begin
            return '0;
        end else if (idx == 4'd15) begin
            return pcPlusOne;         // PC pseudo register
        end
        return regs[idx];
    endfunction

    always_comb begin
        valX = readReg(idxX);
        valY = readReg(idxY);
        valZ = readReg(idxZ);
    end

    // Branches to 15 are taken by the core
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && idxZ != 4'd0 && idxZ != 4'd15) begin
            regs[idxZ] <= writeData;
        end
    end

endmodule

//--- rtl/cpuCore.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module cpuCore (
    input  logic             clk,
    input  logic             reset_n,
    output cpu_pkg::word_t   imemAddr,
    input  cpu_pkg::word_t   imemData,
    output cpu_pkg::memReq_t memReq,
    input  cpu_pkg::word_t   memRdData,
    output logic             halted
);

    cpu_pkg::insnFields_t fields;
    cpu_pkg::corePhase_t  phase;
    cpu_pkg::word_t       valX;
    cpu_pkg::word_t       valY;
    cpu_pkg::word_t       valZ;
    cpu_pkg::word_t       opY;
    cpu_pkg::word_t       opA;
    cpu_pkg::word_t       execResult;
    cpu_pkg::word_t       rhs;
    cpu_pkg::word_t       pcPlusOne;
    logic                 inExec;
    logic                 inCommit;

    assign inExec    = (phase == cpu_pkg::phaseExec);
    assign inCommit  = (phase == cpu_pkg::phaseCommit);
    assign pcPlusOne = imemAddr + 32'd1;

    // Type bit swaps immediate and Y between operand and addend
    assign opY = fields.typeSel ? fields.imm : valY;
    assign opA = fields.typeSel ? valY : fields.imm;

    assign rhs = fields.derefRhs ? memRdData : execResult;  // Load through result address

    // Deref stores Z at the result address, plain stores write result at Z
    assign memReq = '{
        writeEn: inCommit && fields.storing,
        addr:    fields.derefRhs ? execResult : valZ,
        data:    fields.derefRhs ? valZ : execResult
    };

    // Sequencer, PC and halt
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase    <= cpu_pkg::phaseIdle;
            halted   <= 1'b0;
            imemAddr <= `CPU_RESET_VECTOR;
        end else begin
            case (phase)
                cpu_pkg::phaseIdle: begin
                    if (!halted) begin
                        phase <= cpu_pkg::phaseExec;
                    end
                end
                cpu_pkg::phaseExec: begin
                    if (fields.illegal) begin
                        halted <= 1'b1;                 // Skip commit and park
                        phase  <= cpu_pkg::phaseIdle;
                    end else begin
                        phase <= cpu_pkg::phaseCommit;
                    end
                end
                cpu_pkg::phaseCommit: begin
                    phase    <= cpu_pkg::phaseExec;
                    imemAddr <= fields.branch ? rhs : pcPlusOne;
                end
                default: begin
                    phase <= cpu_pkg::phaseIdle;
                end
            endcase
        end
    end

    insnDecoder i_decoder (
        .insn   (imemData),
        .fields (fields)
    );

    aluExec i_exec (
        .clk     (clk),
        .reset_n (reset_n),
        .execEn  (inExec),
        .op      (fields.op),
        .opX     (valX),
        .opY     (opY),
        .opA     (opA),
        .result  (execResult)
    );

    regFile i_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .pcPlusOne (pcPlusOne),
        .idxX      (fields.idxX),
        .idxY      (fields.idxY),
        .idxZ      (fields.idxZ),
        .valX      (valX),
        .valY      (valY),
        .valZ      (valZ),
        .writeEn   (inCommit && !fields.storing),
        .writeData (rhs)
    );

endmodule

//--- rtl/insnMem.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module insnMem (
    input  logic           clk,
    input  logic           loadEn,
    input  cpu_pkg::word_t loadAddr,
    input  cpu_pkg::word_t loadData,
    input  cpu_pkg::word_t fetchAddr,
    output cpu_pkg::word_t fetchData
);

    localparam int memDepth = 2 ** `CPU_IMEM_ADDR_BITS;

    typedef logic [`CPU_IMEM_ADDR_BITS-1:0] imemIndex_t;

    imemIndex_t loadIdx;
    imemIndex_t fetchIdx;

    // Cleared at simulation start so unloaded words read zero
    cpu_pkg::word_t mem [memDepth] = '{default: '0};

    assign loadIdx  = loadAddr[`CPU_IMEM_ADDR_BITS-1:0];
    assign fetchIdx = fetchAddr[`CPU_IMEM_ADDR_BITS-1:0];

    // Load port accepts writes at any time
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;
        end
    end

    assign fetchData = mem[fetchIdx];  // Async fetch

endmodule

//--- rtl/dataMem.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module dataMem (
    input  logic             clk,
    input  cpu_pkg::memReq_t memReq,
    output cpu_pkg::word_t   rdData,
    input  cpu_pkg::word_t   dbgAddr,
    output cpu_pkg::word_t   dbgData
);

    localparam int memDepth = 2 ** `CPU_DMEM_ADDR_BITS;

    typedef logic [`CPU_DMEM_ADDR_BITS-1:0] dmemIndex_t;

    dmemIndex_t coreIdx;
    dmemIndex_t dbgIdx;

    cpu_pkg::word_t mem [memDepth] = '{default: '0};

    assign coreIdx = memReq.addr[`CPU_DMEM_ADDR_BITS-1:0];
    assign dbgIdx  = dbgAddr[`CPU_DMEM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (memReq.writeEn) begin
            mem[coreIdx] <= memReq.data;
        end
    end

    // Both reads are combinational so deref operands land in commit
    assign rdData  = mem[coreIdx];
    assign dbgData = mem[dbgIdx];  // Testbench probe

endmodule

//--- rtl/cpuSystem.sv
`timescale 1ns/1ps

module cpuSystem (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           loadEn,
    input  cpu_pkg::word_t loadAddr,
    input  cpu_pkg::word_t loadData,
    input  cpu_pkg::word_t dbgAddr,
    output cpu_pkg::word_t dbgData,
    output logic           halted
);

    cpu_pkg::word_t   imemAddr;
    cpu_pkg::word_t   imemData;
    cpu_pkg::memReq_t memReq;
    cpu_pkg::word_t   memRdData;

    cpuCore i_core (
        .clk       (clk),
        .reset_n   (reset_n),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .memReq    (memReq),
        .memRdData (memRdData),
        .halted    (halted)
    );

    // Program image comes in through the load port during reset
    insnMem i_imem (
        .clk       (clk),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .fetchAddr (imemAddr),
        .fetchData (imemData)
    );

    dataMem i_dmem (
        .clk     (clk),
        .memReq  (memReq),
        .rdData  (memRdData),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

endmodule

//--- verification/cpuSystem_sva.sv
`timescale 1ns/1ps

module cpuSystem_sva (
    input logic                clk,
    input logic                reset_n,
    input cpu_pkg::corePhase_t phase,
    input logic                halted,
    input logic                memWriteEn,
    input logic                regWriteEn
);

    // Writes land only in commit, the cycle right after exec
    assert property (@(posedge clk) disable iff (!reset_n)
        (memWriteEn || regWriteEn) |-> $past(phase) == cpu_pkg::phaseExec)
    else $error("write strobe outside commit phase");

    assert property (@(posedge clk) disable iff (!reset_n)
        halted |=> halted)
    else $error("halted dropped without reset");

    // Every exec is followed by commit or by the halt park
    assert property (@(posedge clk) disable iff (!reset_n)
        phase == cpu_pkg::phaseExec |=> phase != cpu_pkg::phaseExec)
    else $error("exec phase repeated");

endmodule

bind cpuCore cpuSystem_sva i_sva (
    .clk        (clk),
    .reset_n    (reset_n),
    .phase      (phase),
    .halted     (halted),
    .memWriteEn (memReq.writeEn),
    .regWriteEn (inCommit && !fields.storing)
);

//--- verification/cpuSystem_tb.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module cpuSystem_tb;

    logic           clk;
    logic           reset_n;
    logic           loadEn;
    cpu_pkg::word_t loadAddr;
    cpu_pkg::word_t loadData;
    cpu_pkg::word_t dbgAddr;
    cpu_pkg::word_t dbgData;
    logic           halted;

    int             mismatchErrors;
    int             otherErrors;
    cpu_pkg::word_t prog[$];      // Program image for the next reset
    cpu_pkg::word_t expAddr[$];
    cpu_pkg::word_t expVal[$];

    localparam cpu_pkg::word_t haltWord = 32'hFFFF_FFFF;

    cpuSystem i_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .dbgAddr  (dbgAddr),
        .dbgData  (dbgData),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic cpu_pkg::word_t signExt12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic cpu_pkg::word_t encode(input logic typeSel, input logic storing,
                                              input logic deref, input logic [3:0] z,
                                              input logic [3:0] x, input logic [3:0] y,
                                              input logic [3:0] op, input logic [11:0] imm);
        return {1'b0, typeSel, storing, deref, z, x, y, op, imm};
    endfunction

    // Z gets 0 | 0 plus the immediate
    function automatic cpu_pkg::word_t loadImm(input logic [3:0] z, input logic [11:0] imm);
        return encode(1'b0, 1'b0, 1'b0, z, 4'd0, 4'd0, 4'h0, imm);
    endfunction

    // Deref store: address from immediate, data from Z
    function automatic cpu_pkg::word_t storeReg(input logic [3:0] z, input logic [11:0] addr);
        return encode(1'b0, 1'b1, 1'b1, z, 4'd0, 4'd0, 4'h0, addr);
    endfunction

    function automatic cpu_pkg::word_t aluModel(input logic [3:0] op, input cpu_pkg::word_t x,
                                                input cpu_pkg::word_t y,
                                                input cpu_pkg::word_t a);
        cpu_pkg::word_t f;
        case (op)
            4'h0: f = x | y;
            4'h1: f = x & y;
            4'h2: f = x + y;
            4'h3: f = x * y;
            4'h5: f = (y > 31) ? 32'd0 : x << y[4:0];
            4'h6: f = ($signed(x) < $signed(y)) ? 32'hFFFF_FFFF : 32'd0;
            4'h7: f = (x == y) ? 32'hFFFF_FFFF : 32'd0;
            4'h8: f = ($signed(x) > $signed(y)) ? 32'hFFFF_FFFF : 32'd0;
            4'h9: f = x & ~y;
            4'hA: f = x ^ y;
            4'hB: f = x - y;
            4'hC: f = ~(x ^ y);
            4'hD: f = (y > 31) ? 32'd0 : x >> y[4:0];
            4'hE: f = (x != y) ? 32'hFFFF_FFFF : 32'd0;
            default: f = 32'd0;                    // Reserved, A alone
        endcase
        return f + a;
    endfunction

    task automatic finishRun();
        $display("Errors: %0d mismatch, %0d other", mismatchErrors, otherErrors);
        if (mismatchErrors + otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // Holds reset at least 16 cycles while the image goes in
    task automatic holdResetAndLoad();
        int held;
        held = 0;
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        foreach (prog[i]) begin
            loadEn   = 1'b1;
            loadAddr = `CPU_RESET_VECTOR + i;
            loadData = prog[i];
            @(posedge clk);
            #1;
            held++;
        end
        loadEn = 1'b0;
        while (held < 16) begin
            @(posedge clk);
            #1;
            held++;
        end
        reset_n = 1'b1;
        prog.delete();
    endtask

    task automatic runUntilHalt();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < 2000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (halted === 1'b1) else begin
            otherErrors++;
            $display("Timeout: core did not halt within 2000 cycles");
            finishRun();
        end
    endtask

    task automatic checkWord(input cpu_pkg::word_t addr, input cpu_pkg::word_t exp);
        @(posedge clk);
        #1;
        dbgAddr = addr;
        #2;
        assert (dbgData === exp) else begin
            mismatchErrors++;
            $display("mismatch dbgData[%h]: got %h expected %h", addr, dbgData, exp);
        end
    endtask

    task automatic expectWord(input cpu_pkg::word_t addr, input cpu_pkg::word_t val);
        expAddr.push_back(addr);
        expVal.push_back(val);
    endtask

    task automatic checkExpected();
        foreach (expAddr[i]) begin
            checkWord(expAddr[i], expVal[i]);
        end
        expAddr.delete();
        expVal.delete();
    endtask

    task automatic resetState();
        prog.push_back(haltWord);
        holdResetAndLoad();
        assert (halted === 1'b0) else begin
            otherErrors++;
            $display("halted is not low after reset");
        end
        runUntilHalt();
        for (int a = 0; a < 32; a++) begin
            expectWord(a, 32'd0);
        end
        checkExpected();
    endtask

    // Both operand forms per opcode, results at 0x20 upward
    task automatic arithmeticOps();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        logic [11:0] d;
        logic [3:0]  opCode;
        for (int op = 0; op < 16; op++) begin
            opCode = 4'(op);
            a = 12'($urandom);
            b = 12'($urandom);
            c = 12'($urandom);
            d = 12'($urandom);
            if (opCode == 4'h5 || opCode == 4'hD) begin
                b = b % 12'd32;         // Keep shift counts in range
                c = c % 12'd32;
            end else if (opCode == 4'h7) begin
                b = a;                  // Equal case comes out true
                c = a;
            end
            prog.push_back(loadImm(4'd1, a));
            prog.push_back(loadImm(4'd2, b));
            prog.push_back(encode(1'b0, 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, opCode, d));
            prog.push_back(encode(1'b1, 1'b0, 1'b0, 4'd4, 4'd1, 4'd2, opCode, c));
            prog.push_back(storeReg(4'd3, 12'(32'h20 + 2 * op)));
            prog.push_back(storeReg(4'd4, 12'(32'h21 + 2 * op)));
            expectWord(32'h20 + 2 * op,
                       aluModel(opCode, signExt12(a), signExt12(b), signExt12(d)));
            expectWord(32'h21 + 2 * op,
                       aluModel(opCode, signExt12(a), signExt12(c), signExt12(b)));
        end
        prog.push_back(haltWord);
        holdResetAndLoad();
        runUntilHalt();
        checkExpected();
    endtask

    task automatic specialRegisters();
        prog.push_back(loadImm(4'd1, 12'h5A5));
        prog.push_back(storeReg(4'd1, 12'h040));
        prog.push_back(storeReg(4'd1, 12'h042));
        prog.push_back(storeReg(4'd0, 12'h040));     // Overwrites with zero
        prog.push_back(storeReg(4'd15, 12'h041));    // Index 4, reads 5
        prog.push_back(loadImm(4'd0, 12'h123));
        prog.push_back(storeReg(4'd0, 12'h042));
        prog.push_back(haltWord);
        expectWord(32'h40, 32'd0);
        expectWord(32'h41, `CPU_RESET_VECTOR + 32'd5);
        expectWord(32'h42, 32'd0);
        holdResetAndLoad();
        runUntilHalt();
        checkExpected();
    endtask

    task automatic memoryRoundTrip();
        logic [11:0] v;
        v = 12'($urandom);
        prog.push_back(loadImm(4'd1, v));
        prog.push_back(storeReg(4'd1, 12'h050));
        prog.push_back(encode(1'b0, 1'b0, 1'b1, 4'd2, 4'd0, 4'd0, 4'h0, 12'h050));
        prog.push_back(storeReg(4'd2, 12'h051));
        prog.push_back(loadImm(4'd3, 12'h052));
        prog.push_back(encode(1'b0, 1'b1, 1'b0, 4'd3, 4'd1, 4'd0, 4'h0, 12'h005));
        prog.push_back(encode(1'b0, 1'b1, 1'b1, 4'd1, 4'd3, 4'd0, 4'h2, 12'h001));
        prog.push_back(haltWord);
        expectWord(32'h50, signExt12(v));
        expectWord(32'h51, signExt12(v));
        expectWord(32'h52, signExt12(v) + 32'd5);   // Plain store at Z's value
        expectWord(32'h53, signExt12(v));           // Address from X + 1
        holdResetAndLoad();
        runUntilHalt();
        checkExpected();
    endtask

    task automatic branchSkip();
        prog.push_back(loadImm(4'd1, 12'h3C3));
        prog.push_back(loadImm(4'd15, 12'(`CPU_RESET_VECTOR + 4)));
        prog.push_back(storeReg(4'd1, 12'h060));
        prog.push_back(storeReg(4'd1, 12'h061));
        prog.push_back(storeReg(4'd1, 12'h062));    // Branch target
        prog.push_back(haltWord);
        expectWord(32'h60, 32'd0);
        expectWord(32'h61, 32'd0);
        expectWord(32'h62, 32'h0000_03C3);
        holdResetAndLoad();
        runUntilHalt();
        checkExpected();
    endtask

    task automatic illegalHalt();
        prog.push_back(loadImm(4'd1, 12'h2B7));
        prog.push_back(storeReg(4'd1, 12'h070));
        prog.push_back(haltWord);
        prog.push_back(storeReg(4'd1, 12'h071));
        prog.push_back(storeReg(4'd1, 12'h072));
        prog.push_back(haltWord);
        expectWord(32'h70, 32'h0000_02B7);
        expectWord(32'h71, 32'd0);
        expectWord(32'h72, 32'd0);
        holdResetAndLoad();
        runUntilHalt();
        repeat (20) @(posedge clk);
        #1;
        assert (halted === 1'b1) else begin
            otherErrors++;
            $display("halted dropped after an illegal instruction");
        end
        checkExpected();
    endtask

    initial begin
        reset_n        = 1'b0;
        loadEn         = 1'b0;
        loadAddr       = '0;
        loadData       = '0;
        dbgAddr        = '0;
        mismatchErrors = 0;
        otherErrors    = 0;
        void'($urandom(88));   // Seed the run
        resetState();
        arithmeticOps();
        specialRegisters();
        memoryRoundTrip();
        branchSkip();
        illegalHalt();
        finishRun();
    end

endmodule

//--- cpuSystem.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/insnDecoder.sv
rtl/aluExec.sv
rtl/regFile.sv
rtl/cpuCore.sv
rtl/insnMem.sv
rtl/dataMem.sv
rtl/cpuSystem.sv
verification/cpuSystem_sva.sv
verification/cpuSystem_tb.sv
